// File: ls_array.f
+incdir+logic
logic/ls_array_pkg.sv
logic/precision_lane_decoder.sv
logic/column_sequencer.sv
logic/activation_ls_bank.sv
logic/weight_ls_bank.sv
logic/weight_address_gen.sv
logic/ls_array_top.sv
tb/ls_array_sva.sv
tb/ls_array_tb.sv

// File: Bender.yml
package:
  name: ls_array

sources:
  - include_dirs:
      - logic
    files:
      - logic/ls_array_pkg.sv
      - logic/precision_lane_decoder.sv
      - logic/column_sequencer.sv
      - logic/activation_ls_bank.sv
      - logic/weight_ls_bank.sv
      - logic/weight_address_gen.sv
      - logic/ls_array_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/ls_array_sva.sv
      - tb/ls_array_tb.sv

// File: tb/ls_array_tb.sv
`timescale 1ns/1ps

`include "ls_array_defines.svh"

module ls_array_tb;

    import ls_array_pkg::*;

    // strobe bits of a table step
    localparam logic [8:0] S_COL_CNT = 9'h001;
    localparam logic [8:0] S_COL_LD  = 9'h002;
    localparam logic [8:0] S_WGT_CNT = 9'h004;
    localparam logic [8:0] S_WGT_LD  = 9'h008;
    localparam logic [8:0] S_PAGE_LD = 9'h010;
    localparam logic [8:0] S_FIFO_RD = 9'h020;
    localparam logic [8:0] S_FIFO_WR = 9'h040;
    localparam logic [8:0] S_STORE   = 9'h080;
    localparam logic [8:0] S_WM_RD   = 9'h100;
    localparam logic [8:0] S_ALL     = 9'h1ff;

    // output checks of a table step
    localparam logic [3:0] K_MXU  = 4'h1;
    localparam logic [3:0] K_WGT  = 4'h2;
    localparam logic [3:0] K_OUT  = 4'h4;
    localparam logic [3:0] K_ADDR = 4'h8;
    localparam logic [3:0] K_ALL  = 4'hf;

    localparam int WM_END = `LS_WM_SIZE;

    typedef struct packed {
        precision_e prec;
        logic       en;
        logic [8:0] strobes;
        col_cnt_t   col_max;
        row_cnt_t   w_max;
        wm_addr_t   start;
        logic [3:0] chk;
        logic [7:0] reps;
    } step_t;

    logic       clk;
    logic       reset;
    logic       enable_load_array;
    precision_e data_precision;
    col_ctrl_t  col_ctrl;
    wgt_ctrl_t  wgt_ctrl;
    logic       infifo_read;
    logic       outfifo_write;
    logic       enable_store_activation_data;
    logic       read_weight_memory;
    ls_word_t   input_data_from_fifo;
    act_vec_t   data_from_mxu;
    ls_word_t   data_from_weight_memory;
    ls_word_t   data_to_fifo_out;
    act_vec_t   data_to_mxu;
    wgt_vec_t   weight_to_mxu;
    wm_addr_t   wm_address;

    step_t       steps[$];
    logic [15:0] lfsr_state = 16'd70;
    int          errors = 0;
    int          checks = 0;
    int          run_limit = 0;
    logic        table_ready = 1'b0;

    // reference model state
    act_vec_t m_load;
    act_vec_t m_store;
    wgt_vec_t m_wgt;
    col_cnt_t m_col;
    col_cnt_t m_col_max;
    row_cnt_t m_row;
    row_cnt_t m_row_max;
    wm_page_t m_page;

    ls_array_top i_ls_array_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic ls_word_t next_random_word();
        ls_word_t w;
        for (int i = 0; i < `LS_WORD_W; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w[i] = lfsr_state[0];
        end
        return w;
    endfunction

    function automatic bit strobe_set(input step_t s, input logic [8:0] m);
        return (s.strobes & m) != 0;
    endfunction

    // active lanes = lanes / (word width / element width)
    function automatic int lane_count(input int total, input precision_e p);
        return total / (`LS_WORD_W / (`LS_INT8_BITS << p));
    endfunction

    task automatic add_step(input precision_e prec, input logic en, input logic [8:0] strobes,
                            input col_cnt_t col_max, input row_cnt_t w_max,
                            input wm_addr_t start, input logic [3:0] chk,
                            input logic [7:0] reps);
        steps.push_back('{prec, en, strobes, col_max, w_max, start, chk, reps});
    endtask

    task automatic apply_step(input step_t s);
        enable_load_array                = s.en;
        data_precision                   = s.prec;
        col_ctrl.enable_cnt              = strobe_set(s, S_COL_CNT);
        col_ctrl.ld_max_cnt              = strobe_set(s, S_COL_LD);
        col_ctrl.max_cnt                 = s.col_max;
        wgt_ctrl.enable_cnt_weight       = strobe_set(s, S_WGT_CNT);
        wgt_ctrl.ld_max_cnt_weight       = strobe_set(s, S_WGT_LD);
        wgt_ctrl.max_cnt_weight          = s.w_max;
        wgt_ctrl.ld_weight_page_cnt      = strobe_set(s, S_PAGE_LD);
        wgt_ctrl.start_value_wm          = s.start;
        infifo_read                      = strobe_set(s, S_FIFO_RD);
        outfifo_write                    = strobe_set(s, S_FIFO_WR);
        enable_store_activation_data     = strobe_set(s, S_STORE);
        read_weight_memory               = strobe_set(s, S_WM_RD);
        input_data_from_fifo             = next_random_word();
        data_from_weight_memory          = next_random_word();
        for (int c = 0; c < `LS_COLUMNS; c++) begin
            data_from_mxu[c] = next_random_word();
        end
    endtask

    //////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////
    task automatic check_outputs(input step_t s);
        ls_word_t exp_out;
        wm_addr_t exp_addr;
        exp_out = '0;
        if (strobe_set(s, S_FIFO_WR) && m_col < `LS_COLUMNS) begin
            exp_out = m_store[m_col];
        end
        exp_addr = strobe_set(s, S_WGT_CNT) ? {m_page, m_row[`LS_ROW_SEL_W-1:0]} : '0;
        checks++;
        if ((s.chk & K_MXU) != 0 && data_to_mxu !== m_load) begin
            errors++;
            $display("MISMATCH at %0t: data_to_mxu is %h, expected %h", $time,
                     data_to_mxu, m_load);
        end
        if ((s.chk & K_WGT) != 0 && weight_to_mxu !== m_wgt) begin
            errors++;
            $display("MISMATCH at %0t: weight_to_mxu is %h, expected %h", $time,
                     weight_to_mxu, m_wgt);
        end
        if ((s.chk & K_OUT) != 0 && data_to_fifo_out !== exp_out) begin
            errors++;
            $display("MISMATCH at %0t: data_to_fifo_out is %h, expected %h", $time,
                     data_to_fifo_out, exp_out);
        end
        if ((s.chk & K_ADDR) != 0 && wm_address !== exp_addr) begin
            errors++;
            $display("MISMATCH at %0t: wm_address is %0d, expected %0d", $time,
                     wm_address, exp_addr);
        end
    endtask

    // state after the next rising edge
    task automatic model_update(input step_t s);
        int       nc;
        int       nr;
        wm_addr_t addr;
        nc = lane_count(`LS_COLUMNS, s.prec);
        nr = lane_count(`LS_ROWS, s.prec);
        addr = {m_page, m_row[`LS_ROW_SEL_W-1:0]};
        if (s.en) begin
            for (int c = 0; c < nc; c++) begin
                if (strobe_set(s, S_FIFO_RD) && m_col == c) m_load[c] = input_data_from_fifo;
                if (strobe_set(s, S_STORE)) m_store[c] = data_from_mxu[c];
            end
            for (int r = 0; r < nr; r++) begin
                if (strobe_set(s, S_WM_RD) && m_row == r) m_wgt[r] = data_from_weight_memory;
            end
            if (!strobe_set(s, S_COL_CNT)) m_col = '0;
            else if (m_col == col_cnt_t'(m_col_max - 1)) m_col = '0;
            else m_col = m_col + 1;
            if (strobe_set(s, S_COL_LD)) m_col_max = s.col_max;
            if (strobe_set(s, S_WGT_CNT)) begin
                if (addr == wm_addr_t'(WM_END - 1)) begin
                    m_row  = '0;
                    m_page = '0;
                end else if (m_row == row_cnt_t'(m_row_max - 1)) begin
                    m_row  = '0;
                    m_page = m_page + 1;
                end else begin
                    m_row = m_row + 1;
                end
            end
            if (strobe_set(s, S_WGT_LD)) m_row_max = s.w_max;
            if (strobe_set(s, S_PAGE_LD)) m_page = s.start[`LS_WM_ADDR_W-1:`LS_ROW_SEL_W];
        end
    endtask

    task automatic build_table();
        // idle after reset, all outputs zero
        add_step(INT64, 0, 0, 0, 0, 0, K_ALL, 2);
        // activation loads, widest precision first
        add_step(INT64, 1, S_COL_CNT | S_FIFO_RD, 0, 0, 0, K_ALL, 8);
        add_step(INT8, 1, S_COL_CNT | S_FIFO_RD, 0, 0, 0, K_ALL, 8);
        add_step(INT16, 1, S_COL_CNT | S_FIFO_RD, 0, 0, 0, K_ALL, 8);
        add_step(INT32, 1, S_COL_CNT | S_FIFO_RD, 0, 0, 0, K_ALL, 8);
        // store then read back, counter parks at 0 first
        add_step(INT64, 1, S_STORE, 0, 0, 0, K_ALL, 1);
        add_step(INT64, 1, S_COL_CNT | S_FIFO_WR, 0, 0, 0, K_ALL, 8);
        add_step(INT64, 1, S_COL_CNT, 0, 0, 0, K_ALL, 2);
        add_step(INT16, 1, S_STORE | S_COL_LD, 3, 0, 0, K_ALL, 1);
        add_step(INT16, 1, S_COL_CNT | S_FIFO_WR, 0, 0, 0, K_ALL, 7);
        // weight loads
        add_step(INT64, 1, S_WGT_CNT | S_WM_RD, 0, 0, 0, K_ALL, 8);
        add_step(INT32, 1, S_WGT_CNT | S_WM_RD, 0, 0, 0, K_ALL, 8);
        add_step(INT8, 1, S_WGT_CNT | S_WM_RD, 0, 0, 0, K_ALL, 8);
        // page preset near the end of memory, then the wrap
        add_step(INT64, 1, S_PAGE_LD | S_WGT_LD, 0, 4, WM_END - 16, K_ALL, 1);
        add_step(INT64, 1, S_WGT_CNT | S_WM_RD, 0, 0, 0, K_ALL, 10);
        add_step(INT64, 1, S_PAGE_LD | S_WGT_LD | S_WGT_CNT, 0, 8, WM_END - 8, K_ALL, 1);
        add_step(INT64, 1, S_WGT_CNT, 0, 0, 0, K_ALL, 10);
        add_step(INT64, 1, 0, 0, 0, 0, K_ALL, 2);
        // array disabled, strobes must not matter
        add_step(INT32, 0, S_ALL, 2, 2, 0, K_ALL, 4);
        add_step(INT64, 1, S_COL_CNT | S_FIFO_RD | S_FIFO_WR, 0, 0, 0, K_ALL, 4);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////
    initial begin
        int total;
        reset = 1'b1;
        apply_step('{INT8, 1'b0, 9'h0, 4'h0, 4'h0, 32'h0, 4'h0, 8'h0});
        m_load    = '0;
        m_store   = '0;
        m_wgt     = '0;
        m_col     = '0;
        m_row     = '0;
        m_page    = '0;
        m_col_max = col_cnt_t'(`LS_COLUMNS);
        m_row_max = row_cnt_t'(`LS_ROWS);
        build_table();
        total = 0;
        foreach (steps[i]) total += int'(steps[i].reps);
        run_limit = (total + 4 + 20) * 10;
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (steps[i]) begin
            for (int k = 0; k < int'(steps[i].reps); k++) begin
                @(posedge clk);
                #1;
                apply_step(steps[i]);
                #4;
                check_outputs(steps[i]);
                model_update(steps[i]);
            end
        end
        $display("run complete: %0d cycles checked, %0d mismatches, %0d assertion failures",
                 checks, errors, i_ls_array_top.i_ls_array_sva.failures);
        if (errors == 0 && i_ls_array_top.i_ls_array_sva.failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(run_limit);
        $display("timeout: the table did not finish within %0d ns", run_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: tb/ls_array_sva.sv
`timescale 1ns/1ps

module ls_array_sva (
    input logic                    clk,
    input logic                    reset,
    input ls_array_pkg::wgt_ctrl_t wgt_ctrl,
    input ls_array_pkg::wm_addr_t  wm_address,
    input logic                    outfifo_write,
    input ls_array_pkg::ls_word_t  data_to_fifo_out,
    input logic                    infifo_read,
    input logic                    enable_store_activation_data,
    input ls_array_pkg::act_vec_t  data_to_mxu
);

    int failures = 0;

    // no address request unless the weight counter runs
    address_idle_zero: assert property (
        @(posedge clk) disable iff (reset)
        !wgt_ctrl.enable_cnt_weight |-> (wm_address == '0)
    ) else begin
        $error("wm_address nonzero while enable_cnt_weight is low");
        failures++;
    end

    readback_idle_zero: assert property (
        @(posedge clk) disable iff (reset)
        !outfifo_write |-> (data_to_fifo_out == '0)
    ) else begin
        $error("data_to_fifo_out nonzero while outfifo_write is low");
        failures++;
    end

    // load lanes only move on a fifo read
    lanes_hold: assert property (
        @(posedge clk) disable iff (reset)
        (!infifo_read && !enable_store_activation_data) |=> $stable(data_to_mxu)
    ) else begin
        $error("data_to_mxu changed without a load or store strobe");
        failures++;
    end

endmodule

bind ls_array_top ls_array_sva i_ls_array_sva (
    .clk                          (clk),
    .reset                        (reset),
    .wgt_ctrl                     (wgt_ctrl),
    .wm_address                   (wm_address),
    .outfifo_write                (outfifo_write),
    .data_to_fifo_out             (data_to_fifo_out),
    .infifo_read                  (infifo_read),
    .enable_store_activation_data (enable_store_activation_data),
    .data_to_mxu                  (data_to_mxu)
);

// File: logic/ls_array_top.sv
`timescale 1ns/1ps

module ls_array_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     enable_load_array,
    input  ls_array_pkg::precision_e data_precision,
    input  ls_array_pkg::col_ctrl_t  col_ctrl,
    input  ls_array_pkg::wgt_ctrl_t  wgt_ctrl,
    input  logic                     infifo_read,
    input  logic                     outfifo_write,
    input  logic                     enable_store_activation_data,
    input  logic                     read_weight_memory,
    input  ls_array_pkg::ls_word_t   input_data_from_fifo,
    input  ls_array_pkg::act_vec_t   data_from_mxu,
    input  ls_array_pkg::ls_word_t   data_from_weight_memory,
    output ls_array_pkg::ls_word_t   data_to_fifo_out,
    output ls_array_pkg::act_vec_t   data_to_mxu,
    output ls_array_pkg::wgt_vec_t   weight_to_mxu,
    output ls_array_pkg::wm_addr_t   wm_address
);

    import ls_array_pkg::*;

    col_mask_t col_mask;
    row_mask_t row_mask;
    col_cnt_t  col_count;
    row_cnt_t  row_count;

    //////////////////////////////////////////////////
    // lane enables and counters
    //////////////////////////////////////////////////
    precision_lane_decoder i_precision_lane_decoder (
        .data_precision    (data_precision),
        .enable_load_array (enable_load_array),
        .col_mask          (col_mask),
        .row_mask          (row_mask)
    );

    column_sequencer i_column_sequencer (
        .clk               (clk),
        .reset             (reset),
        .enable_load_array (enable_load_array),
        .col_ctrl          (col_ctrl),
        .col_count         (col_count)
    );

    weight_address_gen i_weight_address_gen (
        .clk               (clk),
        .reset             (reset),
        .enable_load_array (enable_load_array),
        .wgt_ctrl          (wgt_ctrl),
        .row_count         (row_count),
        .wm_address        (wm_address)
    );

    //////////////////////////////////////////////////
    // lane banks
    //////////////////////////////////////////////////
    activation_ls_bank i_activation_ls_bank (
        .clk                          (clk),
        .reset                        (reset),
        .col_mask                     (col_mask),
        .col_count                    (col_count),
        .infifo_read                  (infifo_read),
        .input_data_from_fifo         (input_data_from_fifo),
        .enable_store_activation_data (enable_store_activation_data),
        .data_from_mxu                (data_from_mxu),
        .outfifo_write                (outfifo_write),
        .data_to_mxu                  (data_to_mxu),
        .data_to_fifo_out             (data_to_fifo_out)
    );

    weight_ls_bank i_weight_ls_bank (
        .clk                     (clk),
        .reset                   (reset),
        .row_mask                (row_mask),
        .row_count               (row_count),
        .read_weight_memory      (read_weight_memory),
        .data_from_weight_memory (data_from_weight_memory),
        .weight_to_mxu           (weight_to_mxu)
    );

endmodule

// File: logic/weight_address_gen.sv
`timescale 1ns/1ps

`include "ls_array_defines.svh"

module weight_address_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable_load_array,
    input  ls_array_pkg::wgt_ctrl_t wgt_ctrl,
    output ls_array_pkg::row_cnt_t  row_count,
    output ls_array_pkg::wm_addr_t  wm_address
);

    import ls_array_pkg::*;

    row_cnt_t max_cnt_weight;
    row_cnt_t last_row;
    wm_page_t page_cnt;
    wm_addr_t cur_address;
    logic     end_of_memory;

    assign last_row = max_cnt_weight - 1'b1;

    // page in the upper bits, row select in the lower bits
    assign cur_address   = {page_cnt, row_count[`LS_ROW_SEL_W-1:0]};
    assign end_of_memory = (cur_address == wm_addr_t'(`LS_WM_SIZE - 1));

    //////////////////////////////////////////////////
    // row and page counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            row_count      <= '0;
            page_cnt       <= '0;
            max_cnt_weight <= row_cnt_t'(`LS_ROWS);
        end else if (enable_load_array) begin
            if (wgt_ctrl.enable_cnt_weight) begin
                if (end_of_memory) begin
                    // last word read, start over from address 0
                    row_count <= '0;
                    page_cnt  <= '0;
                end else if (row_count == last_row) begin
                    row_count <= '0;
                    page_cnt  <= page_cnt + 1'b1;
                end else begin
                    row_count <= row_count + 1'b1;
                end
            end

            if (wgt_ctrl.ld_max_cnt_weight) begin
                max_cnt_weight <= wgt_ctrl.max_cnt_weight;
            end

            // preset wins over the carry from the row counter
            if (wgt_ctrl.ld_weight_page_cnt) begin
                page_cnt <= wgt_ctrl.start_value_wm[`LS_WM_ADDR_W-1:`LS_ROW_SEL_W];
            end
        end
    end

    //////////////////////////////////////////////////
    // address request to the weight memory
    //////////////////////////////////////////////////
    assign wm_address = wgt_ctrl.enable_cnt_weight ? cur_address : '0;

endmodule

// File: logic/weight_ls_bank.sv
`timescale 1ns/1ps

`include "ls_array_defines.svh"

module weight_ls_bank (
    input  logic                    clk,
    input  logic                    reset,
    input  ls_array_pkg::row_mask_t row_mask,
    input  ls_array_pkg::row_cnt_t  row_count,
    input  logic                    read_weight_memory,
    input  ls_array_pkg::ls_word_t  data_from_weight_memory,
    output ls_array_pkg::wgt_vec_t  weight_to_mxu
);

    import ls_array_pkg::*;

    wgt_vec_t  wgt_q;
    row_mask_t row_we;

    //////////////////////////////////////////////////
    // row lanes
    //////////////////////////////////////////////////
    for (genvar r = 0; r < `LS_ROWS; r++) begin : g_row
        // memory word goes to the row the address counter points at
        assign row_we[r] = read_weight_memory && row_mask[r] && (row_count == row_cnt_t'(r));

        always_ff @(posedge clk) begin
            if (reset) begin
                wgt_q[r] <= '0;
            end else if (row_we[r]) begin
                wgt_q[r] <= data_from_weight_memory;
            end
        end
    end

    assign weight_to_mxu = wgt_q;

endmodule

// File: logic/activation_ls_bank.sv
`timescale 1ns/1ps

`include "ls_array_defines.svh"

module activation_ls_bank (
    input  logic                    clk,
    input  logic                    reset,
    input  ls_array_pkg::col_mask_t col_mask,
    input  ls_array_pkg::col_cnt_t  col_count,
    input  logic                    infifo_read,
    input  ls_array_pkg::ls_word_t  input_data_from_fifo,
    input  logic                    enable_store_activation_data,
    input  ls_array_pkg::act_vec_t  data_from_mxu,
    input  logic                    outfifo_write,
    output ls_array_pkg::act_vec_t  data_to_mxu,
    output ls_array_pkg::ls_word_t  data_to_fifo_out
);

    import ls_array_pkg::*;

    act_vec_t  load_q;
    act_vec_t  store_q;
    col_mask_t load_we;
    col_mask_t store_we;

    //////////////////////////////////////////////////
    // column lanes
    //////////////////////////////////////////////////
    for (genvar c = 0; c < `LS_COLUMNS; c++) begin : g_col
        // fifo word is broadcast, only the counted lane takes it
        assign load_we[c] = infifo_read && col_mask[c] && (col_count == col_cnt_t'(c));

        // results from the mxu land in every active lane at once
        assign store_we[c] = enable_store_activation_data && col_mask[c];

        always_ff @(posedge clk) begin
            if (reset) begin
                load_q[c] <= '0;
            end else if (load_we[c]) begin
                load_q[c] <= input_data_from_fifo;
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                store_q[c] <= '0;
            end else if (store_we[c]) begin
                store_q[c] <= data_from_mxu[c];
            end
        end
    end

    assign data_to_mxu = load_q;

    //////////////////////////////////////////////////
    // readback mux toward the output fifo
    //////////////////////////////////////////////////
    always_comb begin
        data_to_fifo_out = '0;
        if (outfifo_write) begin
            // counts past the last lane read as zero
            for (int c = 0; c < `LS_COLUMNS; c++) begin
                if (col_count == col_cnt_t'(c)) begin
                    data_to_fifo_out = store_q[c];
                end
            end
        end
    end

endmodule

// File: logic/column_sequencer.sv
`timescale 1ns/1ps

`include "ls_array_defines.svh"

module column_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable_load_array,
    input  ls_array_pkg::col_ctrl_t col_ctrl,
    output ls_array_pkg::col_cnt_t  col_count
);

    import ls_array_pkg::*;

    col_cnt_t max_cnt;
    col_cnt_t last_col;

    assign last_col = max_cnt - 1'b1;

    //////////////////////////////////////////////////
    // column counter, shared by load and readback
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            col_count <= '0;
            max_cnt   <= col_cnt_t'(`LS_COLUMNS);
        end else if (enable_load_array) begin
            if (col_ctrl.enable_cnt) begin
                if (col_count == last_col) begin
                    col_count <= '0;
                end else begin
                    col_count <= col_count + 1'b1;
                end
            end else begin
                // idle counter parks at column 0
                col_count <= '0;
            end

            if (col_ctrl.ld_max_cnt) begin
                max_cnt <= col_ctrl.max_cnt;
            end
        end
    end

endmodule

// File: logic/precision_lane_decoder.sv
`timescale 1ns/1ps

`include "ls_array_defines.svh"

module precision_lane_decoder (
    input  ls_array_pkg::precision_e data_precision,
    input  logic                     enable_load_array,
    output ls_array_pkg::col_mask_t  col_mask,
    output ls_array_pkg::row_mask_t  row_mask
);

    import ls_array_pkg::*;

    int unsigned col_lanes;
    int unsigned row_lanes;

    // lanes needed = lane count / (word width / element width)
    always_comb begin
        case (data_precision)
            INT8: begin
                col_lanes = `LS_COLUMNS / (`LS_WORD_W / `LS_INT8_BITS);
                row_lanes = `LS_ROWS / (`LS_WORD_W / `LS_INT8_BITS);
            end
            INT16: begin
                col_lanes = `LS_COLUMNS / (`LS_WORD_W / `LS_INT16_BITS);
                row_lanes = `LS_ROWS / (`LS_WORD_W / `LS_INT16_BITS);
            end
            INT32: begin
                col_lanes = `LS_COLUMNS / (`LS_WORD_W / `LS_INT32_BITS);
                row_lanes = `LS_ROWS / (`LS_WORD_W / `LS_INT32_BITS);
            end
            INT64: begin
                col_lanes = `LS_COLUMNS / (`LS_WORD_W / `LS_INT64_BITS);
                row_lanes = `LS_ROWS / (`LS_WORD_W / `LS_INT64_BITS);
            end
            default: begin
                col_lanes = 0;
                row_lanes = 0;
            end
        endcase
    end

    // lowest lanes on, everything off while the array is idle
    always_comb begin
        for (int c = 0; c < `LS_COLUMNS; c++) begin
            col_mask[c] = enable_load_array && (c < col_lanes);
        end
        for (int r = 0; r < `LS_ROWS; r++) begin
            row_mask[r] = enable_load_array && (r < row_lanes);
        end
    end

endmodule

// File: logic/ls_array_pkg.sv
`include "ls_array_defines.svh"

package ls_array_pkg;

    // integer precision of the current layer
    typedef enum logic [`LS_PREC_W-1:0] {
        INT8  = 2'd0,
        INT16 = 2'd1,
        INT32 = 2'd2,
        INT64 = 2'd3
    } precision_e;

    typedef logic [`LS_WORD_W-1:0] ls_word_t;

    // one word per lane, lane 0 in the low bits
    typedef logic [`LS_COLUMNS-1:0][`LS_WORD_W-1:0] act_vec_t;
    typedef logic [`LS_ROWS-1:0][`LS_WORD_W-1:0] wgt_vec_t;

    typedef logic [`LS_COLUMNS-1:0] col_mask_t;
    typedef logic [`LS_ROWS-1:0] row_mask_t;

    typedef logic [`LS_COL_CNT_W-1:0] col_cnt_t;
    typedef logic [`LS_ROW_CNT_W-1:0] row_cnt_t;

    typedef logic [`LS_WM_ADDR_W-1:0] wm_addr_t;
    typedef logic [`LS_WM_ADDR_W-`LS_ROW_SEL_W-1:0] wm_page_t;

    // column counter controls from the control unit
    typedef struct packed {
        logic     enable_cnt;
        logic     ld_max_cnt;
        col_cnt_t max_cnt;
    } col_ctrl_t;

    // weight address controls from the control unit
    typedef struct packed {
        logic     enable_cnt_weight;
        logic     ld_max_cnt_weight;
        row_cnt_t max_cnt_weight;
        logic     ld_weight_page_cnt;
        wm_addr_t start_value_wm;
    } wgt_ctrl_t;

endpackage

// File: logic/ls_array_defines.svh
`ifndef LS_ARRAY_DEFINES_SVH
`define LS_ARRAY_DEFINES_SVH

// array geometry
`define LS_COLUMNS 8
`define LS_ROWS 8

// fifo and weight memory words
`define LS_WORD_W 64
`define LS_WM_ADDR_W 32
`define LS_WM_SIZE 2048

// precision code and element widths
`define LS_PREC_W 2
`define LS_INT8_BITS 8
`define LS_INT16_BITS 16
`define LS_INT32_BITS 32
`define LS_INT64_BITS 64

// counters carry one extra bit so a maximum equal to the lane count fits
`define LS_COL_CNT_W ($clog2(`LS_COLUMNS) + 1)
`define LS_ROW_CNT_W ($clog2(`LS_ROWS) + 1)

// row bits inside a weight-memory address
`define LS_ROW_SEL_W ($clog2(`LS_ROWS))

`endif
